//--- hw/cpu_pkg.sv
package cpu_pkg;

	// ------------------------------------------------
	// data widths, bit 0 is the msb
	// ------------------------------------------------

	typedef logic [0:15] word_t;
	typedef logic [0:15] addr_t;
	typedef logic [0:2]  reg_idx_t;
	typedef logic [0:3]  opcode_t;
	typedef logic [0:3]  rsel_t;
	typedef logic [0:1]  flags_t;    // zero, carry
	typedef logic [1:0]  reg_src_t;  // register write-back source

	localparam opcode_t OP_HLT = 4'd0;
	localparam opcode_t OP_LWI = 4'd1;
	localparam opcode_t OP_LD  = 4'd2;
	localparam opcode_t OP_ST  = 4'd3;
	localparam opcode_t OP_ADD = 4'd4;
	localparam opcode_t OP_SUB = 4'd5;
	localparam opcode_t OP_AND = 4'd6;
	localparam opcode_t OP_OR  = 4'd7;
	localparam opcode_t OP_JMP = 4'd8;
	localparam opcode_t OP_JZ  = 4'd9;  // above this: illegal, runs as hlt

	// instruction word fields
	localparam int OPC_POS = 0;
	localparam int RA_POS  = 4;  // destination, st data
	localparam int RB_POS  = 7;  // source, ld/st address

	localparam int FLAG_Z = 0;
	localparam int FLAG_C = 1;

	localparam reg_src_t SRC_ALU = 2'd0;
	localparam reg_src_t SRC_MEM = 2'd1;
	localparam reg_src_t SRC_IMM = 2'd2;

	// panel selector values past the registers
	localparam rsel_t RS_IC    = 4'd8;
	localparam rsel_t RS_IR    = 4'd9;
	localparam rsel_t RS_FLAGS = 4'd10;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_t;

	typedef enum logic [2:0] {
		ST_STOPPED, ST_FETCH, ST_FETCH_ARG, ST_EXEC,
		ST_MEM_RD, ST_MEM_WR, ST_HALTED, ST_ALARM
	} ctl_state_t;

endpackage

//--- hw/cpu_ctl.sv
module cpu_ctl
	import cpu_pkg::*;
#(
	parameter bit STOP_ON_NOMEM = 1'b1
)(
	input  logic       __clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic       stop,
	input  logic       mode,         // step mode
	input  logic       panel_load,
	input  opcode_t    opcode,
	input  alu_op_t    alu_op_dec,
	input  logic       zero,
	input  logic       bus_done,
	input  logic       bus_nomem,
	output logic       run,
	output logic       hlt,
	output logic       alarm,
	output logic       bus_go,
	output logic       bus_we,
	output logic       addr_from_ic,
	output logic       ir_load,
	output logic       arg_load,
	output logic       reg_we,
	output reg_src_t   reg_src,
	output alu_op_t    alu_op,
	output logic       flags_we,
	output logic       ic_inc,
	output logic       ic_jump,
	output logic       ic_panel,
	output logic       ar_load
);

	ctl_state_t state;
	ctl_state_t end_state;  // where an instruction goes when it is done
	logic busy;             // transfer handed to the bus, no answer yet
	logic arg_done;
	logic stop_req;
	logic xfer_end;

	assign run = (state != ST_STOPPED) && (state != ST_HALTED) && (state != ST_ALARM);
	assign hlt = (state == ST_HALTED);
	// without the alarm stop a missing memory just reads as zero
	assign xfer_end = bus_done || (bus_nomem && !STOP_ON_NOMEM);
	assign end_state = (mode || stop || stop_req) ? ST_STOPPED : ST_FETCH;

	// ------------------------------------------------
	// micro-step controls
	// ------------------------------------------------

	always_comb begin
		bus_go = 1'b0;
		bus_we = 1'b0;
		addr_from_ic = 1'b0;
		ir_load = 1'b0;
		arg_load = 1'b0;
		reg_we = 1'b0;
		reg_src = SRC_ALU;
		alu_op = alu_op_dec;
		flags_we = 1'b0;
		ic_inc = 1'b0;
		ic_jump = 1'b0;
		ar_load = 1'b0;
		ic_panel = panel_load && !run;  // kl -> ic only with the cpu idle
		case (state)
			ST_FETCH, ST_FETCH_ARG: begin
				addr_from_ic = 1'b1;
				bus_go = !busy;
				ir_load = xfer_end && (state == ST_FETCH);
				arg_load = xfer_end && (state == ST_FETCH_ARG);
				ic_inc = xfer_end;
			end
			ST_EXEC: begin
				case (opcode)
					OP_LWI: begin
						reg_we = arg_done;
						reg_src = SRC_IMM;
					end
					OP_LD, OP_ST: ar_load = 1'b1;  // address from rB
					OP_ADD, OP_SUB, OP_AND, OP_OR: begin
						reg_we = 1'b1;
						flags_we = 1'b1;
					end
					OP_JMP: ic_jump = arg_done;
					OP_JZ: ic_jump = arg_done && zero;
					default: ;
				endcase
			end
			ST_MEM_RD: begin
				bus_go = !busy;
				reg_we = xfer_end;
				reg_src = SRC_MEM;
			end
			ST_MEM_WR: begin
				bus_go = !busy;
				bus_we = 1'b1;
			end
			default: ;
		endcase
	end

	// ------------------------------------------------
	// sequencer
	// ------------------------------------------------

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= ST_STOPPED;
			busy <= 1'b0;
			arg_done <= 1'b0;
			stop_req <= 1'b0;
			alarm <= 1'b0;
		end else begin
			if (stop)
				stop_req <= 1'b1;  // held until the instruction ends
			if (bus_go)
				busy <= 1'b1;
			else if (bus_done || bus_nomem)
				busy <= 1'b0;
			if (bus_nomem)
				alarm <= 1'b1;
			else if (panel_load)
				alarm <= 1'b0;

			case (state)
				ST_STOPPED, ST_HALTED: begin
					if (start && !panel_load) begin
						state <= ST_FETCH;
						stop_req <= 1'b0;
					end
				end
				ST_ALARM: if (panel_load) state <= ST_STOPPED;
				ST_FETCH: begin
					if (xfer_end) begin
						state <= ST_EXEC;
						arg_done <= 1'b0;
					end
				end
				ST_FETCH_ARG: begin
					if (xfer_end) begin
						state <= ST_EXEC;
						arg_done <= 1'b1;
					end
				end
				ST_EXEC: begin
					case (opcode)
						OP_HLT: state <= ST_HALTED;
						OP_LWI, OP_JMP, OP_JZ: state <= arg_done ? end_state : ST_FETCH_ARG;
						OP_LD: state <= ST_MEM_RD;
						OP_ST: state <= ST_MEM_WR;
						default: state <= end_state;  // register ops, one cycle
					endcase
				end
				ST_MEM_RD, ST_MEM_WR: if (xfer_end) state <= end_state;
				default: state <= ST_STOPPED;
			endcase

			if (bus_nomem && STOP_ON_NOMEM)
				state <= ST_ALARM;
		end
	end

endmodule

//--- hw/cpu_decode.sv
module cpu_decode
	import cpu_pkg::*;
(
	input  logic     __clk,
	input  logic     rst_n,
	input  logic     ir_load,
	input  logic     arg_load,
	input  word_t    rd_data,
	output word_t    ir,
	output opcode_t  opcode,
	output reg_idx_t ra,
	output reg_idx_t rb,
	output word_t    arg,
	output alu_op_t  alu_op_dec
);

	opcode_t raw_op;

	// instruction register, cleared to a hlt word
	always_ff @(posedge __clk) begin
		if (!rst_n)
			ir <= '0;
		else if (ir_load)
			ir <= rd_data;
	end

	// second word: immediate or jump target
	always_ff @(posedge __clk) begin
		if (arg_load)
			arg <= rd_data;
	end

	// ------------------------------------------------
	// field split
	// ------------------------------------------------

	assign raw_op = ir[OPC_POS +: 4];
	assign opcode = (raw_op > OP_JZ) ? OP_HLT : raw_op;  // unknown codes stop the cpu
	assign ra = ir[RA_POS +: 3];
	assign rb = ir[RB_POS +: 3];

	always_comb begin
		case (opcode)
			OP_SUB: alu_op_dec = ALU_SUB;
			OP_AND: alu_op_dec = ALU_AND;
			OP_OR:  alu_op_dec = ALU_OR;
			default: alu_op_dec = ALU_ADD;
		endcase
	end

endmodule

//--- hw/cpu_regs.sv
module cpu_regs
	import cpu_pkg::*;
(
	input  logic     __clk,
	input  logic     rst_n,
	input  logic     reg_we,
	input  reg_src_t reg_src,
	input  reg_idx_t ra,
	input  reg_idx_t rb,
	input  word_t    alu_res,
	input  word_t    rd_data,
	input  word_t    arg,
	input  rsel_t    rs,
	input  addr_t    ic_out,
	input  word_t    ir,
	input  flags_t   flags,
	output word_t    a_val,
	output word_t    b_val,
	output word_t    w
);

	word_t gpr [0:7];
	word_t wb_data;

	always_comb begin
		case (reg_src)
			SRC_MEM: wb_data = rd_data;
			SRC_IMM: wb_data = arg;
			default: wb_data = alu_res;
		endcase
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
		end else if (reg_we) begin
			gpr[ra] <= wb_data;  // rA is always the target
		end
	end

	assign a_val = gpr[ra];
	assign b_val = gpr[rb];

	// panel display word
	always_comb begin
		if (rs < RS_IC) begin
			w = gpr[rs[1:3]];
		end else begin
			case (rs)
				RS_IC:    w = ic_out;
				RS_IR:    w = ir;
				RS_FLAGS: w = {14'b0, flags};  // zero in bit 14, carry in 15
				default:  w = '0;
			endcase
		end
	end

endmodule

//--- hw/cpu_alu.sv
module cpu_alu
	import cpu_pkg::*;
(
	input  logic    __clk,
	input  logic    rst_n,
	input  alu_op_t alu_op,
	input  word_t   a_val,
	input  word_t   b_val,
	input  logic    flags_we,
	input  logic    ic_inc,
	input  logic    ic_jump,
	input  logic    ic_panel,
	input  logic    ar_load,
	input  word_t   arg,
	input  word_t   kl,
	output word_t   alu_res,
	output flags_t  flags,
	output logic    zero,
	output addr_t   ic_out,
	output addr_t   ar_out
);

	logic [0:16] sum;  // bit 0 is carry or borrow

	// ------------------------------------------------
	// arithmetic and logic
	// ------------------------------------------------

	always_comb begin
		case (alu_op)
			ALU_ADD: sum = {1'b0, a_val} + {1'b0, b_val};
			ALU_SUB: sum = {1'b0, a_val} - {1'b0, b_val};
			ALU_AND: sum = {1'b0, a_val & b_val};
			ALU_OR:  sum = {1'b0, a_val | b_val};
			default: sum = '0;
		endcase
	end

	assign alu_res = sum[1:16];

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (flags_we) begin
			flags[FLAG_Z] <= (alu_res == '0);
			flags[FLAG_C] <= sum[0];
		end
	end

	assign zero = flags[FLAG_Z];

	// ------------------------------------------------
	// instruction counter and address register
	// ------------------------------------------------

	always_ff @(posedge __clk) begin
		if (!rst_n)
			ic_out <= '0;
		else if (ic_panel)
			ic_out <= kl;        // load from key switches
		else if (ic_jump)
			ic_out <= arg;
		else if (ic_inc)
			ic_out <= ic_out + 1'b1;
	end

	always_ff @(posedge __clk) begin
		if (ar_load)
			ar_out <= b_val;
	end

endmodule

//--- hw/cpu_bus.sv
module cpu_bus
	import cpu_pkg::*;
#(
	parameter int ALARM_DLY_TICKS = 64
)(
	input  logic  __clk,
	input  logic  rst_n,
	input  logic  bus_go,
	input  logic  bus_we,
	input  logic  addr_from_ic,
	input  addr_t ic_out,
	input  addr_t ar_out,
	input  word_t a_val,
	input  logic  mem_ok,
	input  word_t mem_rdt,
	output logic  mem_req,
	output logic  mem_we,
	output addr_t mem_ad,
	output word_t mem_wdt,
	output word_t rd_data,
	output logic  bus_done,
	output logic  bus_nomem
);

	localparam int CNT_W = $clog2(ALARM_DLY_TICKS + 1);

	logic [CNT_W-1:0] wait_cnt;  // cycles of mem_req without ok
	logic launch;
	logic timeout;

	assign launch = bus_go && !mem_req;
	assign timeout = mem_req && !mem_ok && (wait_cnt == CNT_W'(ALARM_DLY_TICKS - 1));

	// ------------------------------------------------
	// request/ok handshake
	// ------------------------------------------------

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			bus_done <= 1'b0;
			bus_nomem <= 1'b0;
			wait_cnt <= '0;
		end else begin
			bus_done <= 1'b0;
			bus_nomem <= 1'b0;
			if (launch) begin
				mem_req <= 1'b1;
				mem_we <= bus_we;
				wait_cnt <= '0;
			end else if (mem_req) begin
				if (mem_ok) begin
					mem_req <= 1'b0;   // drop the cycle after ok
					bus_done <= 1'b1;
				end else if (timeout) begin
					mem_req <= 1'b0;   // nobody home at this address
					bus_nomem <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt + 1'b1;
				end
			end
		end
	end

	// address and data stay put for the whole request
	always_ff @(posedge __clk) begin
		if (launch) begin
			mem_ad <= addr_from_ic ? ic_out : ar_out;
			mem_wdt <= a_val;
		end
		if (mem_req && mem_ok)
			rd_data <= mem_rdt;
		else if (timeout)
			rd_data <= '0;  // missing memory reads as zero
	end

endmodule

//--- hw/cpu.sv
module cpu
	import cpu_pkg::*;
#(
	parameter int ALARM_DLY_TICKS = 64,
	parameter bit STOP_ON_NOMEM = 1'b1
)(
	input  logic  __clk,
	input  logic  rst_n,

	// control panel
	input  word_t kl,
	input  rsel_t rs,
	input  logic  start,
	input  logic  stop,
	input  logic  mode,
	input  logic  panel_load,
	output word_t w,
	output logic  run,
	output logic  hlt,
	output logic  alarm,

	// system bus
	input  logic  mem_ok,
	input  word_t mem_rdt,
	output logic  mem_req,
	output logic  mem_we,
	output addr_t mem_ad,
	output word_t mem_wdt
);

	logic bus_go, bus_we, addr_from_ic, bus_done, bus_nomem;
	logic ir_load, arg_load, reg_we, flags_we;
	logic ic_inc, ic_jump, ic_panel, ar_load, zero;
	reg_src_t reg_src;
	alu_op_t alu_op, alu_op_dec;
	opcode_t opcode;
	reg_idx_t ra, rb;
	word_t ir, arg, rd_data, a_val, b_val, alu_res;
	addr_t ic_out, ar_out;
	flags_t flags;

	// ------------------------------------------------
	// sequencer
	// ------------------------------------------------

	cpu_ctl #(
		.STOP_ON_NOMEM(STOP_ON_NOMEM)
	) ctl_i (
		.__clk(__clk), .rst_n(rst_n), .start(start), .stop(stop), .mode(mode),
		.panel_load(panel_load), .opcode(opcode), .alu_op_dec(alu_op_dec), .zero(zero),
		.bus_done(bus_done), .bus_nomem(bus_nomem), .run(run), .hlt(hlt), .alarm(alarm),
		.bus_go(bus_go), .bus_we(bus_we), .addr_from_ic(addr_from_ic), .ir_load(ir_load),
		.arg_load(arg_load), .reg_we(reg_we), .reg_src(reg_src), .alu_op(alu_op),
		.flags_we(flags_we), .ic_inc(ic_inc), .ic_jump(ic_jump), .ic_panel(ic_panel),
		.ar_load(ar_load)
	);

	// ------------------------------------------------
	// datapath
	// ------------------------------------------------

	cpu_decode decode_i (
		.__clk(__clk), .rst_n(rst_n), .ir_load(ir_load), .arg_load(arg_load),
		.rd_data(rd_data), .ir(ir), .opcode(opcode), .ra(ra), .rb(rb), .arg(arg),
		.alu_op_dec(alu_op_dec)
	);

	cpu_regs regs_i (
		.__clk(__clk), .rst_n(rst_n), .reg_we(reg_we), .reg_src(reg_src), .ra(ra), .rb(rb),
		.alu_res(alu_res), .rd_data(rd_data), .arg(arg), .rs(rs), .ic_out(ic_out), .ir(ir),
		.flags(flags), .a_val(a_val), .b_val(b_val), .w(w)
	);

	cpu_alu alu_i (
		.__clk(__clk), .rst_n(rst_n), .alu_op(alu_op), .a_val(a_val), .b_val(b_val),
		.flags_we(flags_we), .ic_inc(ic_inc), .ic_jump(ic_jump), .ic_panel(ic_panel),
		.ar_load(ar_load), .arg(arg), .kl(kl), .alu_res(alu_res), .flags(flags),
		.zero(zero), .ic_out(ic_out), .ar_out(ar_out)
	);

	cpu_bus #(
		.ALARM_DLY_TICKS(ALARM_DLY_TICKS)
	) bus_i (
		.__clk(__clk), .rst_n(rst_n), .bus_go(bus_go), .bus_we(bus_we),
		.addr_from_ic(addr_from_ic), .ic_out(ic_out), .ar_out(ar_out), .a_val(a_val),
		.mem_ok(mem_ok), .mem_rdt(mem_rdt), .mem_req(mem_req), .mem_we(mem_we),
		.mem_ad(mem_ad), .mem_wdt(mem_wdt), .rd_data(rd_data), .bus_done(bus_done),
		.bus_nomem(bus_nomem)
	);

endmodule

//--- tests/cpu_mem_model.sv
module cpu_mem_model #(
	parameter int MEM_WORDS = 1024,
	parameter logic [15:0] SEED = 16'd56966
)(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        jitter,    // random ok delay when set
	input  logic        mem_req,
	input  logic        mem_we,
	input  logic [15:0] mem_ad,
	input  logic [15:0] mem_wdt,
	output logic        mem_ok,
	output logic [15:0] mem_rdt
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [1:0] {PH_IDLE, PH_WAIT, PH_DONE} phase_t;

	logic [15:0] mem [0:MEM_WORDS-1];
	logic [15:0] lfsr = SEED;
	logic [2:0] cnt;
	phase_t phase;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
	endfunction

	// top nibble of the fill is an illegal opcode, a stray fetch halts
	initial begin
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = 16'(a) ^ 16'hf0f0;
		mem_ok = 1'b0;
		mem_rdt = '0;
	end

	always @(posedge clk) begin
		logic [2:0] dly;
		mem_ok <= 1'b0;  // one-cycle pulse
		if (!rst_n) begin
			phase <= PH_IDLE;
		end else begin
			case (phase)
				PH_IDLE: if (mem_req) begin
					dly = '0;
					if (jitter) begin
						for (int i = 0; i < 3; i++) begin
							lfsr = lfsr_next(lfsr);
							dly = {dly[1:0], lfsr[15]};
						end
					end
					cnt <= dly;
					phase <= PH_WAIT;
				end
				PH_WAIT: begin
					if (!mem_req)
						phase <= PH_IDLE;  // requester gave up
					else if (cnt != 0)
						cnt <= cnt - 3'd1;
					else if (mem_ad < MEM_WORDS) begin  // hole above: never answers
						mem_ok <= 1'b1;
						mem_rdt <= mem[mem_ad];
						if (mem_we)
							mem[mem_ad] <= mem_wdt;
						phase <= PH_DONE;
					end
				end
				default: if (!mem_req) phase <= PH_IDLE;
			endcase
		end
	end

endmodule

//--- tests/cpu_tb.sv
module cpu_tb
	import cpu_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS = 1024;
	localparam int MAX_CYCLES = 20000;  // 5 runs of up to 40 instr at 80 cycles plus margin

	logic clk, rst_n, start, stop, mode, panel_load, jitter;
	logic [15:0] kl;
	logic [3:0] rs;
	logic run, hlt, alarm, mem_req, mem_we, mem_ok;
	logic [15:0] w, mem_ad, mem_wdt, mem_rdt;
	logic [15:0] lfsr = 16'd56966;
	logic [31:0] wr_q[$];  // expected writes as {address, data}
	logic [15:0] x, y, exp_sub, exp_ic;
	int pc, cycles, err_cnt, chk_cnt;

	cpu dut_i (
		.__clk(clk), .rst_n(rst_n), .kl(kl), .rs(rs), .start(start), .stop(stop),
		.mode(mode), .panel_load(panel_load), .w(w), .run(run), .hlt(hlt), .alarm(alarm),
		.mem_ok(mem_ok), .mem_rdt(mem_rdt), .mem_req(mem_req), .mem_we(mem_we),
		.mem_ad(mem_ad), .mem_wdt(mem_wdt)
	);

	cpu_mem_model #(.MEM_WORDS(MEM_WORDS)) mem_i (
		.clk(clk), .rst_n(rst_n), .jitter(jitter), .mem_req(mem_req), .mem_we(mem_we),
		.mem_ad(mem_ad), .mem_wdt(mem_wdt), .mem_ok(mem_ok), .mem_rdt(mem_rdt)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// bus and lamp assertions
	// --------------------------------------------------

	reset_quiet: assert property (@(posedge clk) !rst_n |=> !(run || hlt || alarm || mem_req))
		else record_fail("lamps or mem_req high in reset");
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && !mem_ok && (mem_ad < MEM_WORDS) |=>
		mem_req && $stable(mem_we) && $stable(mem_ad) && $stable(mem_wdt))
		else record_fail("bus request changed before ok");
	req_drop: assert property (@(posedge clk) disable iff (!rst_n) mem_req && mem_ok |=> !mem_req)
		else record_fail("mem_req not dropped after ok");
	alarm_stop: assert property (@(posedge clk) disable iff (!rst_n) alarm |-> !mem_req && !run)
		else record_fail("cpu still active under alarm");

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the programs did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (rst_n && mem_req && mem_we && mem_ok) begin
			if (wr_q.size() == 0) begin
				err_cnt++;
				$display("write to %h that no program step calls for", mem_ad);
			end else begin
				chk_cnt++;
				assert ({mem_ad, mem_wdt} == wr_q[0])
					else record_fail($sformatf("write %h:%h, expected %h",
						mem_ad, mem_wdt, wr_q[0]));
				void'(wr_q.pop_front());
			end
		end
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	function automatic void record_fail(input string msg);
		err_cnt++;
		$display("FAIL %0t: %s", $time, msg);
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
	endfunction

	function automatic logic [15:0] enc(input logic [3:0] op, input logic [2:0] a,
		input logic [2:0] b);
		return {op, a, b, 6'b0};  // opcode, rA, rB, spare
	endfunction

	task automatic draw_word(output logic [15:0] v);
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[15]};
		end
	endtask

	task automatic emit(input logic [15:0] v);
		mem_i.mem[pc] = v;
		pc++;
	endtask

	task automatic reset_cpu();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic load_ic(input logic [15:0] entry);
		@(posedge clk);
		kl <= entry;
		panel_load <= 1'b1;
		@(posedge clk);
		panel_load <= 1'b0;
	endtask

	task automatic run_program(input logic [15:0] entry);
		load_ic(entry);
		pulse_start();
		while (!(hlt || alarm))
			@(posedge clk);
	endtask

	task automatic check_w(input logic [3:0] sel, input logic [15:0] exp);
		@(posedge clk);
		rs <= sel;
		@(posedge clk);
		chk_cnt++;
		assert (w == exp)
			else record_fail($sformatf("rs %0d shows %h, expected %h", sel, w, exp));
	endtask

	// results land at 0x200..0x203 in op order
	task automatic arith_program();
		pc = 0;
		emit(enc(OP_LWI, 1, 0));
		emit(x);
		emit(enc(OP_LWI, 2, 0));
		emit(y);
		emit(enc(OP_LWI, 3, 0));
		emit(x);
		emit(enc(OP_LWI, 4, 0));
		emit(x);
		emit(enc(OP_LWI, 5, 0));
		emit(x);
		emit(enc(OP_ADD, 1, 2));
		emit(enc(OP_SUB, 3, 2));
		emit(enc(OP_AND, 4, 2));
		emit(enc(OP_OR, 5, 2));
		for (int i = 0; i < 4; i++) begin
			emit(enc(OP_LWI, 6, 0));
			emit(16'h0200 + 16'(i));
			emit(enc(OP_ST, 3'(i == 0 ? 1 : i + 2), 6));
		end
		emit(enc(OP_HLT, 0, 0));
		exp_sub = x - y;
		wr_q.push_back({16'h0200, 16'(x + y)});
		wr_q.push_back({16'h0201, exp_sub});
		wr_q.push_back({16'h0202, x & y});
		wr_q.push_back({16'h0203, x | y});
	endtask

	task automatic arith_run();
		reset_cpu();
		arith_program();
		run_program(16'h0000);
		chk_cnt++;
		assert (hlt && wr_q.size() == 0)
			else record_fail("arithmetic program ended early");
		check_w(0, 16'h0000);
		check_w(1, 16'(x + y));
		check_w(2, y);
		check_w(3, exp_sub);
		check_w(4, x & y);
		check_w(5, x | y);
		check_w(6, 16'h0203);
		check_w(7, 16'h0000);
		check_w(10, {14'b0, (x | y) == 16'h0000, 1'b0});  // flags left by the or
		wr_q.delete();
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		mode = 1'b0;
		panel_load = 1'b0;
		jitter = 1'b0;
		kl = '0;
		rs = '0;
		draw_word(x);
		draw_word(y);

		jitter <= 1'b0;
		arith_run();
		jitter <= 1'b1;  // same program under back-pressure
		arith_run();

		// jz taken then jz not taken and jmp to the hlt at 0x110
		reset_cpu();
		pc = 16'h0100;
		emit(enc(OP_LWI, 1, 0));
		emit(16'd5);
		emit(enc(OP_LWI, 2, 0));
		emit(16'd5);
		emit(enc(OP_SUB, 1, 2));
		emit(enc(OP_JZ, 0, 0));
		emit(16'h0108);
		emit(enc(OP_HLT, 0, 0));
		emit(enc(OP_LWI, 3, 0));
		emit(16'd1);
		emit(enc(OP_OR, 3, 3));
		emit(enc(OP_JZ, 0, 0));
		emit(16'h010f);
		emit(enc(OP_JMP, 0, 0));
		emit(16'h0110);
		emit(enc(OP_HLT, 0, 0));
		emit(enc(OP_HLT, 0, 0));
		run_program(16'h0100);
		check_w(8, 16'h0111);
		check_w(1, 16'h0000);

		// step mode over lwi, add and hlt
		reset_cpu();
		pc = 16'h0180;
		emit(enc(OP_LWI, 1, 0));
		emit(16'd3);
		emit(enc(OP_ADD, 1, 1));
		emit(enc(OP_HLT, 0, 0));
		mode <= 1'b1;
		load_ic(16'h0180);
		exp_ic = 16'h0180;
		for (int i = 0; i < 3; i++) begin
			pulse_start();
			while (!run)
				@(posedge clk);
			while (run)
				@(posedge clk);
			exp_ic += (i == 0) ? 16'd2 : 16'd1;  // lwi is two words long
			check_w(8, exp_ic);
		end
		chk_cnt++;
		assert (hlt)
			else record_fail("hlt lamp low after the last step");
		check_w(1, 16'd6);
		mode <= 1'b0;

		// ld from the hole above memory
		reset_cpu();
		pc = 16'h01c0;
		emit(enc(OP_LWI, 1, 0));
		emit(16'h8000);
		emit(enc(OP_LD, 2, 1));
		emit(enc(OP_HLT, 0, 0));
		run_program(16'h01c0);
		repeat (130) @(posedge clk);  // no further request may show up
		chk_cnt++;
		assert (alarm && !run && !hlt)
			else record_fail("no alarm stop after a missing memory");

		$display("checks %0d, errors %0d, cycles %0d", chk_cnt, err_cnt, cycles);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- cpu.f
hw/cpu_pkg.sv
hw/cpu_ctl.sv
hw/cpu_decode.sv
hw/cpu_regs.sv
hw/cpu_alu.sv
hw/cpu_bus.sv
hw/cpu.sv
tests/cpu_mem_model.sv
tests/cpu_tb.sv

//--- Makefile
# Verilator build and run of the cpu testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS"

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
